// ==== design/ex_pkg.sv ====
//////////////////////////////////////////////////
// Execute stage shared definitions
// Datapath widths, ALU and multiplier opcodes and
// the special-purpose register count
//////////////////////////////////////////////////

`default_nettype none

package ex_pkg;

  localparam int unsigned DATA_W     = 32;
  localparam int unsigned REG_ADDR_W = 6;
  localparam int unsigned LANE_W     = 8;  // One dot-product lane
  localparam int unsigned NUM_LANES  = DATA_W / LANE_W;
  localparam int unsigned NUM_SPR    = 2;

  // Scalar ALU operations, compares last
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11
  } alu_op_e;

  typedef enum logic [1:0] {
    MUL_LO  = 2'd0,  // Low word of product
    MUL_HI  = 2'd1,  // Signed high word, two cycles
    MUL_DOT = 2'd2   // Lane dot product plus accumulator
  } mult_op_e;

endpackage

`default_nettype wire

// ==== design/ex_alu.sv ====
//////////////////////////////////////////////////
// Scalar ALU
// Add, subtract, logic, shifts and compares.
// The compare flag doubles as branch decision
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module ex_alu (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire logic                      enable_i,
  input  wire ex_pkg::alu_op_e           operator_i,
  input  wire logic [ex_pkg::DATA_W-1:0] operand_a_i,
  input  wire logic [ex_pkg::DATA_W-1:0] operand_b_i,
  output logic      [ex_pkg::DATA_W-1:0] result_o,
  output logic                           cmp_result_o
);

  logic [4:0] shamt;
  logic       is_equal;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = operand_b_i[4:0];
  assign is_equal    = (operand_a_i == operand_b_i);
  assign lt_signed   = ($signed(operand_a_i) < $signed(operand_b_i));
  assign lt_unsigned = (operand_a_i < operand_b_i);

  // Branch compare
  always_comb begin
    case (operator_i)
      ex_pkg::ALU_EQ:   cmp_result_o = is_equal;
      ex_pkg::ALU_NE:   cmp_result_o = ~is_equal;
      ex_pkg::ALU_SLT:  cmp_result_o = lt_signed;
      ex_pkg::ALU_SLTU: cmp_result_o = lt_unsigned;
      default:          cmp_result_o = 1'b0;
    endcase
  end

  always_comb begin
    case (operator_i)
      ex_pkg::ALU_ADD: result_o = operand_a_i + operand_b_i;
      ex_pkg::ALU_SUB: result_o = operand_a_i - operand_b_i;
      ex_pkg::ALU_AND: result_o = operand_a_i & operand_b_i;
      ex_pkg::ALU_OR:  result_o = operand_a_i | operand_b_i;
      ex_pkg::ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      ex_pkg::ALU_SLL: result_o = operand_a_i << shamt;
      ex_pkg::ALU_SRL: result_o = operand_a_i >> shamt;
      ex_pkg::ALU_SRA: result_o = $unsigned($signed(operand_a_i) >>> shamt);
      ex_pkg::ALU_SLT, ex_pkg::ALU_SLTU,
      ex_pkg::ALU_EQ,  ex_pkg::ALU_NE:
        result_o = {{(ex_pkg::DATA_W-1){1'b0}}, cmp_result_o};
      default:         result_o = '0;
    endcase
  end

  // Decoder must never hand over an unused encoding
  a_legal_op: assert property (@(posedge clk) disable iff (!rst_n)
    enable_i |-> operator_i <= ex_pkg::ALU_NE)
    else $error("ALU enabled with illegal operator %0d", operator_i);

endmodule

`default_nettype wire

// ==== design/ex_dotp_mult.sv ====
//////////////////////////////////////////////////
// Multiplier with dot-product lanes
// Low product and lane dot product in one cycle,
// signed high word in two cycles
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module ex_dotp_mult (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire logic                      enable_i,
  input  wire ex_pkg::mult_op_e          operator_i,
  input  wire logic [ex_pkg::DATA_W-1:0] op_a_i,
  input  wire logic [ex_pkg::DATA_W-1:0] op_b_i,
  input  wire logic [ex_pkg::DATA_W-1:0] op_c_i,
  input  wire logic [ex_pkg::DATA_W-1:0] dot_op_a_i,
  input  wire logic [ex_pkg::DATA_W-1:0] dot_op_b_i,
  input  wire logic [1:0]                dot_signed_i,
  input  wire logic                      ex_ready_i,
  output logic      [ex_pkg::DATA_W-1:0] result_o,
  output logic                           multicycle_o,
  output logic                           ready_o
);

  typedef enum logic {IDLE, HIGH_STEP} hi_state_e;

  hi_state_e                         state_q;
  logic                              hi_start;
  logic signed [2*ex_pkg::DATA_W-1:0] part_lo;
  logic signed [2*ex_pkg::DATA_W-1:0] part_hi;
  logic signed [2*ex_pkg::DATA_W-1:0] partial_q;
  logic signed [2*ex_pkg::DATA_W-1:0] hi_prod;
  logic        [ex_pkg::LANE_W:0]    lane_a [ex_pkg::NUM_LANES];
  logic        [ex_pkg::LANE_W:0]    lane_b [ex_pkg::NUM_LANES];
  logic signed [ex_pkg::DATA_W-1:0]  lane_prod [ex_pkg::NUM_LANES];
  logic        [ex_pkg::DATA_W-1:0]  dot_sum;

  assign hi_start     = enable_i && (operator_i == ex_pkg::MUL_HI) && (state_q == IDLE);
  assign ready_o      = ~hi_start;
  assign multicycle_o = hi_start;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else if (hi_start) begin
      state_q <= HIGH_STEP;
    end else if (state_q == HIGH_STEP && ex_ready_i) begin
      state_q <= IDLE;  // Hold the result until the stage moves on
    end
  end

  ///////////////////////////////////////////////////
  // High word, b split into unsigned low half and
  // signed high half
  ///////////////////////////////////////////////////
  assign part_lo = $signed(op_a_i) * $signed({1'b0, op_b_i[15:0]});
  assign part_hi = $signed(op_a_i) * $signed(op_b_i[31:16]);
  assign hi_prod = partial_q + (part_hi <<< 16);

  always_ff @(posedge clk) begin
    if (hi_start) partial_q <= part_lo;  // First step
  end

  ///////////////////////////////////////////////////
  // Dot product lanes
  ///////////////////////////////////////////////////
  for (genvar i = 0; i < ex_pkg::NUM_LANES; i++) begin : g_lane
    assign lane_a[i] = {dot_signed_i[0] & dot_op_a_i[ex_pkg::LANE_W*(i+1)-1],
                        dot_op_a_i[ex_pkg::LANE_W*i +: ex_pkg::LANE_W]};
    assign lane_b[i] = {dot_signed_i[1] & dot_op_b_i[ex_pkg::LANE_W*(i+1)-1],
                        dot_op_b_i[ex_pkg::LANE_W*i +: ex_pkg::LANE_W]};
    assign lane_prod[i] = $signed(lane_a[i]) * $signed(lane_b[i]);
  end

  always_comb begin
    dot_sum = op_c_i;
    for (int i = 0; i < ex_pkg::NUM_LANES; i++) begin
      dot_sum = dot_sum + lane_prod[i];
    end
  end

  always_comb begin
    case (operator_i)
      ex_pkg::MUL_LO:  result_o = op_a_i * op_b_i;
      ex_pkg::MUL_HI:  result_o = hi_prod[2*ex_pkg::DATA_W-1:ex_pkg::DATA_W];
      ex_pkg::MUL_DOT: result_o = dot_sum;
      default:         result_o = '0;
    endcase
  end

  // Second step reuses the operands of the first
  a_hi_operands_held: assert property (@(posedge clk) disable iff (!rst_n)
    !ready_o |=> enable_i && operator_i == ex_pkg::MUL_HI &&
                 $stable(op_a_i) && $stable(op_b_i))
    else $error("MUL_HI operands changed before the second step");

endmodule

`default_nettype wire

// ==== design/ex_spr_bank.sv ====
//////////////////////////////////////////////////
// Special-purpose register bank
// Loaded from memory data, may replace dot-product
// operand a. Also keeps last cycle's mult result
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module ex_spr_bank (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire logic [1:0]                tospr_ex_i,  // {index, enable}
  input  wire logic                      load_spr_i,
  input  wire logic                      load_idx_i,
  input  wire logic [ex_pkg::DATA_W-1:0] lsu_rdata_i,
  input  wire logic [ex_pkg::DATA_W-1:0] dot_op_a_i,
  input  wire logic [ex_pkg::DATA_W-1:0] mult_result_i,
  output logic      [ex_pkg::DATA_W-1:0] dot_op_a_o,
  output logic      [ex_pkg::DATA_W-1:0] mult_result_p_o
);

  logic [ex_pkg::DATA_W-1:0] spr_q [ex_pkg::NUM_SPR];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < ex_pkg::NUM_SPR; i++) begin
        spr_q[i] <= '0;
      end
    end else if (load_spr_i) begin
      spr_q[load_idx_i] <= lsu_rdata_i;  // Written in the writeback cycle
    end
  end

  // Dot result one cycle old, sent out on the LSU port
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mult_result_p_o <= '0;
    end else begin
      mult_result_p_o <= mult_result_i;
    end
  end

  assign dot_op_a_o = tospr_ex_i[0] ? spr_q[tospr_ex_i[1]] : dot_op_a_i;

endmodule

`default_nettype wire

// ==== design/ex_wb_ctrl.sv ====
//////////////////////////////////////////////////
// Execute stage writeback control
// ALU forwarding mux, LSU write port, EX/WB
// register and stage ready/valid
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module ex_wb_ctrl (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  input  wire logic                          alu_en_i,
  input  wire logic                          mult_en_i,
  input  wire logic                          csr_access_i,
  input  wire logic                          lsu_en_i,
  input  wire logic [ex_pkg::DATA_W-1:0]     alu_result_i,
  input  wire logic [ex_pkg::DATA_W-1:0]     mult_result_i,
  input  wire logic [ex_pkg::DATA_W-1:0]     csr_rdata_i,
  input  wire logic [ex_pkg::DATA_W-1:0]     lsu_rdata_i,
  input  wire logic [ex_pkg::DATA_W-1:0]     mult_result_p_i,
  input  wire logic                          regfile_alu_we_i,
  input  wire logic [ex_pkg::REG_ADDR_W-1:0] regfile_alu_waddr_i,
  input  wire logic                          regfile_we_i,
  input  wire logic [ex_pkg::REG_ADDR_W-1:0] regfile_waddr_i,
  input  wire logic [1:0]                    tospr_ex_i,
  input  wire logic                          mult_ready_i,
  input  wire logic                          lsu_ready_ex_i,
  input  wire logic                          lsu_err_i,
  input  wire logic                          wb_ready_i,
  input  wire logic                          branch_in_ex_i,
  output logic                               regfile_alu_we_fw_o,
  output logic      [ex_pkg::REG_ADDR_W-1:0] regfile_alu_waddr_fw_o,
  output logic      [ex_pkg::DATA_W-1:0]     regfile_alu_wdata_fw_o,
  output logic                               regfile_we_wb_o,
  output logic      [ex_pkg::REG_ADDR_W-1:0] regfile_waddr_wb_o,
  output logic      [ex_pkg::DATA_W-1:0]     regfile_wdata_wb_o,
  output logic                               load_spr_o,
  output logic                               load_idx_o,
  output logic                               compute_load_vliw_o,
  output logic                               ex_ready_o,
  output logic                               ex_valid_o
);

  logic                          units_ready;
  logic                          lsu_we_q;
  logic [ex_pkg::REG_ADDR_W-1:0] lsu_waddr_q;
  logic [1:0]                    tospr_wb_q;

  assign compute_load_vliw_o = alu_en_i & mult_en_i;

  // ALU write port, csr over mult over alu unless both compute units run
  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;
  always_comb begin
    if (compute_load_vliw_o) regfile_alu_wdata_fw_o = alu_result_i;
    else if (csr_access_i)   regfile_alu_wdata_fw_o = csr_rdata_i;
    else if (mult_en_i)      regfile_alu_wdata_fw_o = mult_result_i;
    else if (alu_en_i)       regfile_alu_wdata_fw_o = alu_result_i;
    else                     regfile_alu_wdata_fw_o = '0;
  end

  //////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_we_q    <= 1'b0;
      lsu_waddr_q <= '0;
      tospr_wb_q  <= 2'b00;
    end else if (ex_valid_o) begin
      lsu_we_q   <= regfile_we_i & ~lsu_err_i;
      tospr_wb_q <= tospr_ex_i;
      if (regfile_we_i && !lsu_err_i) lsu_waddr_q <= regfile_waddr_i;
    end else if (wb_ready_i) begin
      lsu_we_q <= 1'b0;  // Nothing arrived, drain
    end
  end

  // LSU port, SPR loads write back the old dot result
  assign regfile_we_wb_o    = lsu_we_q;
  assign regfile_waddr_wb_o = lsu_waddr_q;
  assign regfile_wdata_wb_o = tospr_wb_q[0] ? mult_result_p_i : lsu_rdata_i;
  assign load_spr_o         = lsu_we_q & tospr_wb_q[0];
  assign load_idx_o         = tospr_wb_q[1];

  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;
  assign ex_ready_o  = units_ready | branch_in_ex_i;
  assign ex_valid_o  = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

  // Upstream keeps a pending write until the stage takes it
  a_waddr_held: assert property (@(posedge clk) disable iff (!rst_n)
    regfile_we_i && !ex_ready_o |=> regfile_we_i && $stable(regfile_waddr_i))
    else $error("Write request changed while the stage was stalled");

endmodule

`default_nettype wire

// ==== design/ex_stage.sv ====
//////////////////////////////////////////////////
// Execute stage top
// ALU, dot-product multiplier, SPR bank and
// writeback control
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module ex_stage (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  // ALU
  input  wire ex_pkg::alu_op_e               alu_operator_i,
  input  wire logic [ex_pkg::DATA_W-1:0]     alu_operand_a_i,
  input  wire logic [ex_pkg::DATA_W-1:0]     alu_operand_b_i,
  input  wire logic [ex_pkg::DATA_W-1:0]     alu_operand_c_i,
  input  wire logic                          alu_en_i,
  // Multiplier
  input  wire ex_pkg::mult_op_e              mult_operator_i,
  input  wire logic [ex_pkg::DATA_W-1:0]     mult_operand_a_i,
  input  wire logic [ex_pkg::DATA_W-1:0]     mult_operand_b_i,
  input  wire logic [ex_pkg::DATA_W-1:0]     mult_operand_c_i,
  input  wire logic                          mult_en_i,
  input  wire logic [ex_pkg::DATA_W-1:0]     mult_dot_op_a_i,
  input  wire logic [ex_pkg::DATA_W-1:0]     mult_dot_op_b_i,
  input  wire logic [1:0]                    mult_dot_signed_i,
  output logic                               mult_multicycle_o,
  // LSU and SPR
  input  wire logic                          lsu_en_i,
  input  wire logic [ex_pkg::DATA_W-1:0]     lsu_rdata_i,
  input  wire logic [1:0]                    lsu_tospr_ex_i,
  input  wire logic                          lsu_ready_ex_i,
  input  wire logic                          lsu_err_i,
  output logic                               compute_load_vliw_o,
  // Register file and CSR
  input  wire logic                          regfile_alu_we_i,
  input  wire logic [ex_pkg::REG_ADDR_W-1:0] regfile_alu_waddr_i,
  input  wire logic                          regfile_we_i,
  input  wire logic [ex_pkg::REG_ADDR_W-1:0] regfile_waddr_i,
  input  wire logic                          csr_access_i,
  input  wire logic [ex_pkg::DATA_W-1:0]     csr_rdata_i,
  output logic                               regfile_we_wb_o,
  output logic      [ex_pkg::REG_ADDR_W-1:0] regfile_waddr_wb_o,
  output logic      [ex_pkg::DATA_W-1:0]     regfile_wdata_wb_o,
  output logic                               regfile_alu_we_fw_o,
  output logic      [ex_pkg::REG_ADDR_W-1:0] regfile_alu_waddr_fw_o,
  output logic      [ex_pkg::DATA_W-1:0]     regfile_alu_wdata_fw_o,
  // Branch and stage flow
  input  wire logic                          branch_in_ex_i,
  output logic                               branch_decision_o,
  output logic      [ex_pkg::DATA_W-1:0]     jump_target_o,
  input  wire logic                          wb_ready_i,
  output logic                               ex_ready_o,
  output logic                               ex_valid_o
);

  logic [ex_pkg::DATA_W-1:0] alu_result;
  logic [ex_pkg::DATA_W-1:0] mult_result;
  logic [ex_pkg::DATA_W-1:0] mult_result_p;
  logic [ex_pkg::DATA_W-1:0] dot_op_a;  // After SPR substitution
  logic                      mult_ready;
  logic                      load_spr;
  logic                      load_idx;

  assign jump_target_o = alu_operand_c_i;

  ex_alu alu_inst (
    .clk, .rst_n,
    .enable_i     (alu_en_i),
    .operator_i   (alu_operator_i),
    .operand_a_i  (alu_operand_a_i),
    .operand_b_i  (alu_operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (branch_decision_o)
  );

  ex_dotp_mult mult_inst (
    .clk, .rst_n,
    .enable_i     (mult_en_i),
    .operator_i   (mult_operator_i),
    .op_a_i       (mult_operand_a_i),
    .op_b_i       (mult_operand_b_i),
    .op_c_i       (mult_operand_c_i),
    .dot_op_a_i   (dot_op_a),
    .dot_op_b_i   (mult_dot_op_b_i),
    .dot_signed_i (mult_dot_signed_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .multicycle_o (mult_multicycle_o),
    .ready_o      (mult_ready)
  );

  ex_spr_bank spr_inst (
    .clk, .rst_n,
    .tospr_ex_i      (lsu_tospr_ex_i),
    .load_spr_i      (load_spr),
    .load_idx_i      (load_idx),
    .lsu_rdata_i     (lsu_rdata_i),
    .dot_op_a_i      (mult_dot_op_a_i),
    .mult_result_i   (mult_result),
    .dot_op_a_o      (dot_op_a),
    .mult_result_p_o (mult_result_p)
  );

  ex_wb_ctrl wb_ctrl_inst (
    .clk, .rst_n,
    .alu_en_i, .mult_en_i, .csr_access_i, .lsu_en_i,
    .alu_result_i           (alu_result),
    .mult_result_i          (mult_result),
    .csr_rdata_i, .lsu_rdata_i,
    .mult_result_p_i        (mult_result_p),
    .regfile_alu_we_i, .regfile_alu_waddr_i, .regfile_we_i, .regfile_waddr_i,
    .tospr_ex_i             (lsu_tospr_ex_i),
    .mult_ready_i           (mult_ready),
    .lsu_ready_ex_i, .lsu_err_i, .wb_ready_i, .branch_in_ex_i,
    .regfile_alu_we_fw_o, .regfile_alu_waddr_fw_o, .regfile_alu_wdata_fw_o,
    .regfile_we_wb_o, .regfile_waddr_wb_o, .regfile_wdata_wb_o,
    .load_spr_o             (load_spr),
    .load_idx_o             (load_idx),
    .compute_load_vliw_o, .ex_ready_o, .ex_valid_o
  );

endmodule

`default_nettype wire

// ==== tests/tb_ex_stage.sv ====
//////////////////////////////////////////////////
// Execute stage testbench
// Random operands against a reference model, with
// concurrent checks on forwarding, multiplier,
// LSU write port and SPR path
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_ex_stage;

  localparam int unsigned WAIT_LIMIT = 16;  // Cycles before a handshake wait gives up

  logic                          clk;
  logic                          rst_n;
  ex_pkg::alu_op_e               alu_operator_i;
  ex_pkg::mult_op_e              mult_operator_i;
  logic [ex_pkg::DATA_W-1:0]     alu_operand_a_i, alu_operand_b_i, alu_operand_c_i;
  logic [ex_pkg::DATA_W-1:0]     mult_operand_a_i, mult_operand_b_i, mult_operand_c_i;
  logic [ex_pkg::DATA_W-1:0]     mult_dot_op_a_i, mult_dot_op_b_i, lsu_rdata_i, csr_rdata_i;
  logic [1:0]                    mult_dot_signed_i, lsu_tospr_ex_i;
  logic                          alu_en_i, mult_en_i, lsu_en_i, csr_access_i, branch_in_ex_i;
  logic                          lsu_ready_ex_i, lsu_err_i, wb_ready_i;
  logic                          regfile_alu_we_i, regfile_we_i;
  logic [ex_pkg::REG_ADDR_W-1:0] regfile_alu_waddr_i, regfile_waddr_i;
  // DUT outputs
  logic                          mult_multicycle_o, compute_load_vliw_o, branch_decision_o;
  logic                          regfile_we_wb_o, regfile_alu_we_fw_o, ex_ready_o, ex_valid_o;
  logic [ex_pkg::REG_ADDR_W-1:0] regfile_waddr_wb_o, regfile_alu_waddr_fw_o;
  logic [ex_pkg::DATA_W-1:0]     regfile_wdata_wb_o, regfile_alu_wdata_fw_o, jump_target_o;

  // Reference model
  logic [ex_pkg::DATA_W-1:0]     exp_alu, exp_mult, exp_fw, exp_wdata, dot_a_eff, prev_mult_q;
  logic [ex_pkg::DATA_W-1:0]     spr_model [ex_pkg::NUM_SPR];
  logic                          exp_cmp, hi_first, hi_second_q, exp_ready, exp_valid, exp_we_q;
  logic [1:0]                    exp_tospr_q;
  logic [ex_pkg::REG_ADDR_W-1:0] exp_waddr_q;
  string                         test_name;
  integer                        seed;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ex_stage ex_stage_inst (.*);

  //////////////////////////////////////////////////
  // Reference functions
  //////////////////////////////////////////////////
  function automatic logic cmp_ref(input ex_pkg::alu_op_e op, input logic [31:0] a, b);
    case (op)
      ex_pkg::ALU_EQ:   return a == b;
      ex_pkg::ALU_NE:   return a != b;
      ex_pkg::ALU_SLT:  return (a[31] != b[31]) ? a[31] : (a < b);  // Signs differ, a negative
      ex_pkg::ALU_SLTU: return a < b;
      default:          return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] alu_ref(input ex_pkg::alu_op_e op, input logic [31:0] a, b);
    logic [63:0] ext;
    ext = {{32{a[31]}}, a} >> b[4:0];  // Arithmetic shift from a widened word
    case (op)
      ex_pkg::ALU_ADD: return a + b;
      ex_pkg::ALU_SUB: return a + ~b + 32'd1;
      ex_pkg::ALU_AND: return a & b;
      ex_pkg::ALU_OR:  return a | b;
      ex_pkg::ALU_XOR: return a ^ b;
      ex_pkg::ALU_SLL: return a << b[4:0];
      ex_pkg::ALU_SRL: return a >> b[4:0];
      ex_pkg::ALU_SRA: return ext[31:0];
      default:         return {31'd0, cmp_ref(op, a, b)};
    endcase
  endfunction

  function automatic logic [31:0] mult_ref(input ex_pkg::mult_op_e op, input logic [31:0] a, b,
                                           input logic [31:0] c, da, db, input logic [1:0] sgn);
    logic [63:0] wide;
    logic [31:0] la;
    logic [31:0] lb;
    logic [31:0] sum;
    wide = {{32{a[31]}}, a} * {{32{b[31]}}, b};
    sum  = c;
    for (int i = 0; i < 4; i++) begin
      la  = {{24{sgn[0] & da[8*i+7]}}, da[8*i +: 8]};
      lb  = {{24{sgn[1] & db[8*i+7]}}, db[8*i +: 8]};
      sum = sum + la * lb;
    end
    case (op)
      ex_pkg::MUL_LO: return wide[31:0];
      ex_pkg::MUL_HI: return wide[63:32];
      default:        return sum;
    endcase
  endfunction

  always_comb begin
    dot_a_eff = lsu_tospr_ex_i[0] ? spr_model[lsu_tospr_ex_i[1]] : mult_dot_op_a_i;
    exp_alu   = alu_ref(alu_operator_i, alu_operand_a_i, alu_operand_b_i);
    exp_cmp   = cmp_ref(alu_operator_i, alu_operand_a_i, alu_operand_b_i);
    exp_mult  = mult_ref(mult_operator_i, mult_operand_a_i, mult_operand_b_i, mult_operand_c_i,
                         dot_a_eff, mult_dot_op_b_i, mult_dot_signed_i);
    hi_first  = mult_en_i && (mult_operator_i == ex_pkg::MUL_HI) && !hi_second_q;
    exp_ready = (!hi_first && lsu_ready_ex_i && wb_ready_i) || branch_in_ex_i;
    exp_valid = (alu_en_i || mult_en_i || csr_access_i || lsu_en_i) && !hi_first &&
                lsu_ready_ex_i && wb_ready_i;
    if (alu_en_i && mult_en_i) exp_fw = exp_alu;  // VLIW pair
    else if (csr_access_i)     exp_fw = csr_rdata_i;
    else if (mult_en_i)        exp_fw = exp_mult;
    else if (alu_en_i)         exp_fw = exp_alu;
    else                       exp_fw = '0;
    exp_wdata = exp_tospr_q[0] ? prev_mult_q : lsu_rdata_i;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hi_second_q  <= 1'b0;
      exp_we_q     <= 1'b0;
      exp_waddr_q  <= '0;
      exp_tospr_q  <= 2'b00;
      prev_mult_q  <= '0;
      spr_model[0] <= '0;
      spr_model[1] <= '0;
    end else begin
      if (hi_first) hi_second_q <= 1'b1;
      else if (exp_ready) hi_second_q <= 1'b0;
      prev_mult_q <= exp_mult;
      if (exp_valid) begin
        exp_we_q    <= regfile_we_i & ~lsu_err_i;
        exp_waddr_q <= regfile_waddr_i;
        exp_tospr_q <= lsu_tospr_ex_i;
      end else if (wb_ready_i) begin
        exp_we_q <= 1'b0;
      end
      if (exp_we_q && exp_tospr_q[0]) spr_model[exp_tospr_q[1]] <= lsu_rdata_i;
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////
  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1, "Stopped at first failure");
  endtask

  task automatic stop_run(input string msg);
    $display("Error in %s: %s", test_name, msg);
    abort_run();
  endtask

  task automatic report_mismatch(input string check, input logic [31:0] exp_val, act_val);
    $display("** Error [%s] %s: expected 0x%08h, actual 0x%08h",
             test_name, check, exp_val, act_val);
    abort_run();
  endtask

  a_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !regfile_we_wb_o && !mult_multicycle_o)
    else stop_run("write port or multiplier busy after reset");
  a_fw_data: assert property (@(posedge clk) disable iff (!rst_n)
    (alu_en_i || mult_en_i || csr_access_i) && !hi_first |-> regfile_alu_wdata_fw_o == exp_fw)
    else report_mismatch("forward data", $sampled(exp_fw), $sampled(regfile_alu_wdata_fw_o));
  a_fw_port: assert property (@(posedge clk) disable iff (!rst_n)
    regfile_alu_we_fw_o == regfile_alu_we_i && regfile_alu_waddr_fw_o == regfile_alu_waddr_i)
    else stop_run("forwarding port address or enable differs from its input");
  a_vliw: assert property (@(posedge clk) disable iff (!rst_n)
    compute_load_vliw_o == (alu_en_i && mult_en_i))
    else report_mismatch("vliw", 32'($sampled(alu_en_i && mult_en_i)),
                         32'($sampled(compute_load_vliw_o)));
  a_branch: assert property (@(posedge clk) disable iff (!rst_n)
    alu_en_i |-> branch_decision_o == exp_cmp)
    else report_mismatch("branch", 32'($sampled(exp_cmp)), 32'($sampled(branch_decision_o)));
  a_jump: assert property (@(posedge clk) disable iff (!rst_n) jump_target_o == alu_operand_c_i)
    else report_mismatch("jump", $sampled(alu_operand_c_i), $sampled(jump_target_o));
  a_ready: assert property (@(posedge clk) disable iff (!rst_n) ex_ready_o == exp_ready)
    else report_mismatch("ex_ready", 32'($sampled(exp_ready)), 32'($sampled(ex_ready_o)));
  a_valid: assert property (@(posedge clk) disable iff (!rst_n) ex_valid_o == exp_valid)
    else report_mismatch("ex_valid", 32'($sampled(exp_valid)), 32'($sampled(ex_valid_o)));
  a_multicycle: assert property (@(posedge clk) disable iff (!rst_n) mult_multicycle_o == hi_first)
    else report_mismatch("multicycle", 32'($sampled(hi_first)), 32'($sampled(mult_multicycle_o)));
  a_hi_stall: assert property (@(posedge clk) disable iff (!rst_n) hi_first |=> ex_ready_o)
    else stop_run("ex_ready_o still low one cycle after a MUL_HI stall");
  a_wb_we: assert property (@(posedge clk) disable iff (!rst_n) regfile_we_wb_o == exp_we_q)
    else report_mismatch("wb enable", 32'($sampled(exp_we_q)), 32'($sampled(regfile_we_wb_o)));
  a_wb_addr: assert property (@(posedge clk) disable iff (!rst_n)
    exp_we_q |-> regfile_waddr_wb_o == exp_waddr_q)
    else report_mismatch("wb address", 32'($sampled(exp_waddr_q)),
                         32'($sampled(regfile_waddr_wb_o)));
  a_wb_data: assert property (@(posedge clk) disable iff (!rst_n)
    exp_we_q |-> regfile_wdata_wb_o == exp_wdata)
    else report_mismatch("wb data", $sampled(exp_wdata), $sampled(regfile_wdata_wb_o));

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////
  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic logic [ex_pkg::REG_ADDR_W-1:0] rand_addr();
    logic [31:0] w;
    w = $random(seed);
    return w[ex_pkg::REG_ADDR_W-1:0];
  endfunction

  // Holds the current inputs until the stage takes them
  task automatic wait_accept();
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) stop_run("ex_ready_o never rose");
    end while (!ex_ready_o);
  endtask

  task automatic clear_inputs();
    alu_en_i         <= 1'b0;
    mult_en_i        <= 1'b0;
    lsu_en_i         <= 1'b0;
    csr_access_i     <= 1'b0;
    regfile_we_i     <= 1'b0;
    regfile_alu_we_i <= 1'b0;
    lsu_err_i        <= 1'b0;
    lsu_tospr_ex_i   <= 2'b00;
    branch_in_ex_i   <= 1'b0;
  endtask

  initial begin
    logic [31:0] rnd;
    seed      = 32'ha2a0_27cc;
    test_name = "reset";
    rst_n     = 1'b0;
    alu_operator_i  = ex_pkg::ALU_ADD;
    mult_operator_i = ex_pkg::MUL_LO;
    {alu_operand_a_i, alu_operand_b_i, alu_operand_c_i, csr_rdata_i, lsu_rdata_i} = '0;
    {mult_operand_a_i, mult_operand_b_i, mult_operand_c_i} = '0;
    {mult_dot_op_a_i, mult_dot_op_b_i, mult_dot_signed_i, lsu_tospr_ex_i} = '0;
    {alu_en_i, mult_en_i, lsu_en_i, csr_access_i, branch_in_ex_i, lsu_err_i} = '0;
    {regfile_alu_we_i, regfile_we_i, regfile_alu_waddr_i, regfile_waddr_i} = '0;
    lsu_ready_ex_i = 1'b1;
    wb_ready_i     = 1'b1;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    test_name = "alu";
    for (int op = 0; op < 12; op++) begin
      for (int k = 0; k < 3; k++) begin
        rnd = rand_word();
        alu_en_i            <= 1'b1;
        alu_operator_i      <= ex_pkg::alu_op_e'(op);
        alu_operand_a_i     <= rnd;
        alu_operand_b_i     <= (k == 0) ? rnd : rand_word();  // Equal pair once
        alu_operand_c_i     <= rand_word();
        branch_in_ex_i      <= (op >= 8);
        regfile_alu_we_i    <= 1'b1;
        regfile_alu_waddr_i <= rand_addr();
        wait_accept();
      end
    end

    test_name = "forwarding";
    clear_inputs();
    for (int k = 0; k < 5; k++) begin
      alu_en_i         <= (k == 1) || (k >= 3);
      mult_en_i        <= (k == 0) || (k == 2) || (k == 4);
      csr_access_i     <= (k < 2);
      csr_rdata_i      <= rand_word();
      alu_operator_i   <= ex_pkg::ALU_XOR;
      mult_operator_i  <= ex_pkg::MUL_LO;
      mult_operand_a_i <= rand_word();
      mult_operand_b_i <= rand_word();
      wait_accept();
    end

    test_name = "multiplier";
    clear_inputs();
    for (int k = 0; k < 12; k++) begin
      mult_en_i         <= 1'b1;
      mult_operator_i   <= ex_pkg::mult_op_e'(k % 3);
      mult_dot_signed_i <= 2'((k / 3) % 4);
      mult_operand_a_i  <= rand_word();
      mult_operand_b_i  <= rand_word();
      mult_operand_c_i  <= rand_word();
      mult_dot_op_a_i   <= rand_word();
      mult_dot_op_b_i   <= rand_word();
      wait_accept();
    end

    test_name = "lsu";
    clear_inputs();
    for (int k = 0; k < 4; k++) begin
      lsu_en_i        <= 1'b1;
      regfile_we_i    <= 1'b1;
      regfile_waddr_i <= rand_addr();
      lsu_err_i       <= (k == 2);  // Faulting load writes nothing
      lsu_rdata_i     <= rand_word();
      wait_accept();
    end
    test_name = "back-pressure";
    wb_ready_i <= 1'b0;
    repeat (2) @(posedge clk);
    branch_in_ex_i <= 1'b1;  // Branch overrides the stall
    @(posedge clk);
    branch_in_ex_i <= 1'b0;
    wb_ready_i     <= 1'b1;
    lsu_ready_ex_i <= 1'b0;  // LSU not ready for one cycle
    @(posedge clk);
    lsu_ready_ex_i <= 1'b1;
    wait_accept();

    test_name = "spr";
    for (int k = 0; k < 2; k++) begin
      // SPR-directed load with a dot product alongside
      lsu_en_i        <= 1'b1;
      regfile_we_i    <= 1'b1;
      regfile_waddr_i <= rand_addr();
      lsu_tospr_ex_i  <= {k[0], 1'b1};
      mult_en_i       <= 1'b1;
      mult_operator_i <= ex_pkg::MUL_DOT;
      mult_dot_op_a_i <= rand_word();
      mult_dot_op_b_i <= rand_word();
      wait_accept();
      clear_inputs();
      lsu_rdata_i <= rand_word();  // New SPR value
      wait_accept();
      mult_en_i       <= 1'b1;
      lsu_tospr_ex_i  <= {k[0], 1'b1};
      mult_dot_op_a_i <= rand_word();
      wait_accept();
    end

    clear_inputs();
    wait_accept();
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
design/ex_pkg.sv
design/ex_alu.sv
design/ex_dotp_mult.sv
design/ex_spr_bank.sv
design/ex_wb_ctrl.sv
design/ex_stage.sv
tests/tb_ex_stage.sv

// ==== Bender.yml ====
package:
  name: ex_stage

sources:
  # Package first, then the units, then the top level
  - design/ex_pkg.sv
  - design/ex_alu.sv
  - design/ex_dotp_mult.sv
  - design/ex_spr_bank.sv
  - design/ex_wb_ctrl.sv
  - design/ex_stage.sv

  - target: test
    files:
      - tests/tb_ex_stage.sv
